/* hw/collatz_pkg.sv */
// collatz explorer shared types
package collatz_pkg;

  // arithmetic widths
  localparam int value_bits = 32; // trajectory register width
  localparam int step_bits  = 16; // per-trial step counter width

  // start value or current trajectory value
  typedef logic [value_bits-1:0] value_t;

  // number of shortcut steps taken in one trial
  typedef logic [step_bits-1:0] step_t;

  // controller sequence, one pass per trial
  typedef enum logic [1:0] {
    st_idle,    // wait for run or a host load
    st_load,    // start and actual capture the new start value
    st_iterate, // one shortcut step per enabled cycle
    st_report   // done pulse, tally commit, lfsr advance
  } ctrl_state_t;

endpackage

/* hw/seed_lfsr.sv */
// galois lfsr start source
`timescale 1ns/1ns
module seed_lfsr
  import collatz_pkg::*;
#(
  parameter int explore_bits = 20 // lfsr width, 4 to 31
)
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   clken,    // global hold when low
  input  logic   lfsr_adv, // step to the next state
  output value_t seed      // state, zero extended
);

  // maximal length tap masks for a right shifting galois lfsr
  // bit k of the mask stands for the x^(k+1) term of the polynomial
  function automatic logic [30:0] tap_mask(input int width);
    case (width)
      4:       tap_mask = 31'h0000_000c;
      5:       tap_mask = 31'h0000_0014;
      6:       tap_mask = 31'h0000_0030;
      7:       tap_mask = 31'h0000_0060;
      8:       tap_mask = 31'h0000_00b8;
      9:       tap_mask = 31'h0000_0110;
      10:      tap_mask = 31'h0000_0240;
      11:      tap_mask = 31'h0000_0500;
      12:      tap_mask = 31'h0000_0e08;
      13:      tap_mask = 31'h0000_1c80;
      14:      tap_mask = 31'h0000_3802;
      15:      tap_mask = 31'h0000_6000;
      16:      tap_mask = 31'h0000_d008;
      17:      tap_mask = 31'h0001_2000;
      18:      tap_mask = 31'h0002_0400;
      19:      tap_mask = 31'h0007_2000;
      20:      tap_mask = 31'h0009_0000;
      21:      tap_mask = 31'h0014_0000;
      22:      tap_mask = 31'h0030_0000;
      23:      tap_mask = 31'h0042_0000;
      24:      tap_mask = 31'h00e1_0000;
      25:      tap_mask = 31'h0120_0000;
      26:      tap_mask = 31'h0200_0023;
      27:      tap_mask = 31'h0400_0013;
      28:      tap_mask = 31'h0900_0000;
      29:      tap_mask = 31'h1400_0000;
      30:      tap_mask = 31'h2000_0029;
      31:      tap_mask = 31'h4800_0000;
      default: tap_mask = 31'h0; // width outside the supported range
    endcase
  endfunction

  localparam logic [explore_bits-1:0] taps = explore_bits'(tap_mask(explore_bits));

  logic [explore_bits-1:0] state_q; // never zero, so every start is nonzero

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      state_q <= '1; // all ones, first lfsr trial starts here
    else if (clken && lfsr_adv)
      state_q <= state_q[0] ? (state_q >> 1) ^ taps : state_q >> 1; // shift out lsb
  end

  assign seed = value_t'(state_q);

endmodule

/* hw/collatz_step.sv */
// shortcut collatz datapath
`timescale 1ns/1ns
module collatz_step
  import collatz_pkg::*;
#(
  parameter int done_bits = 4 // trial ends below 2**done_bits
)
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   clken,       // global hold when low
  input  logic   step_load,   // capture a new start value
  input  logic   step_en,     // take one step this cycle
  input  logic   source_host, // 1 selects load_value, 0 the lfsr seed
  input  value_t load_value,  // host start, held until the load state
  input  value_t seed,        // lfsr start
  output value_t start,
  output value_t actual,
  output logic   finished,    // actual is in the explored range
  output logic   ovf          // 3x+1 carried out, sticky
);

  value_t start_q;
  value_t actual_q;
  logic   ovf_q;

  // 3x+1 as ((x << 1) | 1) + x with two spare bits for the carry
  logic [value_bits+1:0] triple;
  logic                  carry;   // 3x+1 does not fit in value_bits
  value_t                next_val;

  assign triple = {1'b0, actual_q, 1'b1} + {2'b00, actual_q};
  assign carry  = |triple[value_bits+1:value_bits];

  // odd x becomes (3x+1)/2, even x becomes x/2
  assign next_val = actual_q[0] ? triple[value_bits:1] : actual_q >> 1;

  // start and trajectory registers
  always_ff @(posedge clk)
  begin
    if (clken)
    begin
      if (step_load)
      begin
        start_q  <= source_host ? load_value : seed;
        actual_q <= source_host ? load_value : seed;
      end
      else if (step_en)
        actual_q <= next_val; // truncated value on overflow, trial ends anyway
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      ovf_q <= 1'b0;
    else if (clken)
    begin
      if (step_load)
        ovf_q <= 1'b0; // new trial
      else if (step_en && actual_q[0] && carry)
        ovf_q <= 1'b1; // held until the next load
    end
  end

  assign finished = ~|actual_q[value_bits-1:done_bits]; // all high bits clear
  assign ovf      = ovf_q;
  assign start    = start_q;
  assign actual   = actual_q;

endmodule

/* hw/step_tally.sv */
// step count and longest trial record
`timescale 1ns/1ns
module step_tally
  import collatz_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   clken,        // global hold when low
  input  logic   step_en,      // one step taken this cycle
  input  logic   tally_clear,  // new trial
  input  logic   tally_commit, // trial over, latch results
  input  value_t start,        // start of the current trial
  input  logic   aborted,      // skip or step cap ended the trial
  input  logic   ovf,          // trial ended on overflow
  output step_t  count,        // running count, seen by the controller
  output step_t  steps,        // count of the last finished trial
  output logic   overflow,     // overflow of the last trial
  output value_t record_start,
  output step_t  record_steps
);

  step_t  count_q;
  step_t  steps_q;
  logic   overflow_q;
  value_t record_start_q;
  step_t  record_steps_q;
  logic   new_record;

  // only clean trials compete, ties keep the older record
  assign new_record = !aborted && !ovf && (count_q > record_steps_q);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count_q        <= '0;
      steps_q        <= '0;
      overflow_q     <= 1'b0;
      record_start_q <= '0;
      record_steps_q <= '0;
    end
    else if (clken)
    begin
      if (tally_clear)
        count_q <= '0;
      else if (step_en)
        count_q <= count_q + 1'b1; // controller caps it at step_limit

      if (tally_commit)
      begin
        steps_q    <= count_q;
        overflow_q <= ovf;
        if (new_record)
        begin
          record_start_q <= start;
          record_steps_q <= count_q;
        end
      end
    end
  end

  assign count        = count_q;
  assign steps        = steps_q;
  assign overflow     = overflow_q;
  assign record_start = record_start_q;
  assign record_steps = record_steps_q;

endmodule

/* hw/collatz_ctrl.sv */
// collatz trial controller
`timescale 1ns/1ns
module collatz_ctrl
  import collatz_pkg::*;
#(
  parameter int step_limit = 1000 // runaway trial cap
)
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  clken,        // global hold when low
  input  logic  run,          // level, start lfsr trials back to back
  input  logic  load,         // pulse, start a trial from load_value
  input  logic  skip,         // pulse, abandon the current trial
  input  logic  finished,     // trajectory reached the explored range
  input  logic  ovf,          // arithmetic overflow in this trial
  input  step_t count,        // steps taken so far
  output logic  lfsr_adv,     // pulse, next lfsr state
  output logic  step_load,    // pulse, capture start value
  output logic  source_host,  // start value select for step_load
  output logic  step_en,      // level, one step per cycle
  output logic  tally_clear,  // pulse, zero the step count
  output logic  tally_commit, // pulse, latch steps and record
  output logic  active,       // trial iterating
  output logic  done,         // pulse, trial result valid
  output logic  aborted       // last trial ended by skip or cap
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        from_host_q; // trial started by a host load
  logic        aborted_q;
  logic        at_limit;    // count reached step_limit
  logic        stop;        // any reason to leave iterate

  assign at_limit = count >= step_t'(step_limit);
  assign stop     = skip || finished || ovf || at_limit;

  // next state
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle:
        if (load || run)
          state_d = st_load; // load wins, see from_host_q
      st_load:
        state_d = st_iterate;
      st_iterate:
        if (stop)
          state_d = st_report; // a start already in range leaves with 0 steps
      st_report:
        state_d = st_idle;
      default:
        state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q     <= st_idle;
      from_host_q <= 1'b0;
      aborted_q   <= 1'b0;
    end
    else if (clken)
    begin
      state_q <= state_d;
      if (state_q == st_idle)
        from_host_q <= load; // remember the source for the lfsr advance
      if (state_q == st_iterate && stop)
        aborted_q <= skip || (!finished && !ovf && at_limit); // skip first, then a clean end
    end
  end

  // pulses are one enabled cycle wide
  assign step_load    = clken && (state_q == st_load);
  assign tally_clear  = clken && (state_q == st_load);
  assign tally_commit = clken && (state_q == st_report);
  assign done         = clken && (state_q == st_report);
  assign lfsr_adv     = clken && (state_q == st_report) && !from_host_q; // lfsr trials only

  assign source_host = from_host_q;
  assign step_en     = (state_q == st_iterate) && !stop; // no step on the exit cycle
  assign active      = (state_q == st_iterate);
  assign aborted     = aborted_q; // holds until the next trial ends

endmodule

/* hw/collatz_explorer.sv */
// collatz explorer top level
`timescale 1ns/1ns
module collatz_explorer
  import collatz_pkg::*;
#(
  parameter int explore_bits = 20,  // lfsr width, 4 to 31
  parameter int done_bits    = 4,   // explored range is below 2**done_bits
  parameter int step_limit   = 1000 // abort a trial after this many steps
)
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   clken,        // low freezes every state
  input  logic   run,          // level, lfsr trials back to back
  input  logic   load,         // pulse, trial from load_value
  input  value_t load_value,   // hold stable one cycle past load
  input  logic   skip,         // pulse, abandon the trial
  output logic   active,       // trial iterating
  output logic   done,         // pulse, results valid
  output value_t start,
  output value_t actual,
  output step_t  steps,        // steps of the last trial
  output logic   overflow,     // last trial overflowed
  output logic   aborted,      // last trial skipped or capped
  output value_t record_start, // longest clean trial so far
  output step_t  record_steps
);

  // controller to datapath
  logic   lfsr_adv;
  logic   step_load;
  logic   source_host;
  logic   step_en;
  logic   tally_clear;
  logic   tally_commit;

  // datapath to controller
  logic   finished;
  logic   ovf;
  step_t  count;
  value_t seed;

  collatz_ctrl #(
    .step_limit (step_limit)
  ) u_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .clken        (clken),
    .run          (run),
    .load         (load),
    .skip         (skip),
    .finished     (finished),
    .ovf          (ovf),
    .count        (count),
    .lfsr_adv     (lfsr_adv),
    .step_load    (step_load),
    .source_host  (source_host),
    .step_en      (step_en),
    .tally_clear  (tally_clear),
    .tally_commit (tally_commit),
    .active       (active),
    .done         (done),
    .aborted      (aborted)
  );

  seed_lfsr #(
    .explore_bits (explore_bits)
  ) u_lfsr (
    .clk      (clk),
    .arst_n   (arst_n),
    .clken    (clken),
    .lfsr_adv (lfsr_adv),
    .seed     (seed)
  );

  collatz_step #(
    .done_bits (done_bits)
  ) u_step (
    .clk         (clk),
    .arst_n      (arst_n),
    .clken       (clken),
    .step_load   (step_load),
    .step_en     (step_en),
    .source_host (source_host),
    .load_value  (load_value),
    .seed        (seed),
    .start       (start),
    .actual      (actual),
    .finished    (finished),
    .ovf         (ovf)
  );

  step_tally u_tally (
    .clk          (clk),
    .arst_n       (arst_n),
    .clken        (clken),
    .step_en      (step_en),
    .tally_clear  (tally_clear),
    .tally_commit (tally_commit),
    .start        (start),
    .aborted      (aborted),
    .ovf          (ovf),
    .count        (count),
    .steps        (steps),
    .overflow     (overflow),
    .record_start (record_start),
    .record_steps (record_steps)
  );

endmodule

/* sim/collatz_explorer_checker.sv */
// controller protocol assertions
`timescale 1ns/1ns
module collatz_explorer_checker
(
  input logic clk,
  input logic arst_n,
  input logic clken,
  input logic run,
  input logic load,
  input logic done,
  input logic active
);

  logic started_q; // a run or load was accepted since reset

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      started_q <= 1'b0;
    else if (clken && (run || load))
      started_q <= 1'b1;
  end

  // report lasts exactly one enabled cycle
  done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  done_not_active: assert property (@(posedge clk) disable iff (!arst_n) !(done && active))
    else $error("done and active high in the same cycle");

  // nothing may happen before the first request
  quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
    !started_q |-> (!done && !active))
    else $error("done or active rose before any run or load");

endmodule

bind collatz_ctrl collatz_explorer_checker u_checker (
  .clk    (clk),
  .arst_n (arst_n),
  .clken  (clken),
  .run    (run),
  .load   (load),
  .done   (done),
  .active (active)
);

/* sim/collatz_explorer_tb.sv */
// collatz explorer testbench
`timescale 1ns/1ns
module collatz_explorer_tb
  import collatz_pkg::*;
();

  localparam int explore_bits = 8;
  localparam int done_bits    = 1;   // trials end below 2
  localparam int step_limit   = 200;
  localparam int num_table    = 8;
  localparam int num_random   = 8;
  localparam int num_run      = 6;   // back to back lfsr trials
  localparam int num_trials   = num_table + num_random + num_run + 2; // plus skip and hold
  localparam int watchdog_ns  = (num_trials * (step_limit + 4) + 100) * 20;

  // load value, steps, overflow, aborted
  localparam value_t table_value [num_table] = '{
    32'hffff_ffff, 32'd1, 32'd2, 32'd3, 32'd7, 32'd27, 32'd0, 32'd837799
  };
  localparam step_t table_steps [num_table] = '{
    16'd1, 16'd0, 16'd1, 16'd5, 16'd11, 16'd70, 16'd0, 16'd200
  };
  localparam logic table_ovf   [num_table] = '{1, 0, 0, 0, 0, 0, 0, 0}; // 3x+1 carry on all ones
  localparam logic table_abort [num_table] = '{0, 0, 0, 0, 0, 0, 0, 1}; // 837799 runs past the cap

  logic   clk = 1'b0;
  logic   arst_n;
  logic   clken;
  logic   run;
  logic   load;
  value_t load_value;
  logic   skip;
  logic   active;
  logic   done;
  value_t start;
  value_t actual;
  step_t  steps;
  logic   overflow;
  logic   aborted;
  value_t record_start;
  step_t  record_steps;

  value_t     rec_start;                // reference record
  step_t      rec_steps;
  logic [7:0] lfsr_model;               // reference lfsr state
  integer     seed = 32'h4c6d_c557;

  always #10 clk = ~clk;

  collatz_explorer #(
    .explore_bits (explore_bits),
    .done_bits    (done_bits),
    .step_limit   (step_limit)
  ) u_dut (.*);

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERRORS FOUND");
    $display("mismatch %s: got %h expected %h", name, got, exp);
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else report_mismatch(name, got, exp);
  endtask

  // shortcut rule on a 64 bit copy so the carry shows above value_bits
  task automatic model_trial(input value_t v, output step_t n, output logic o,
                             output logic a);
    logic [63:0] x;
    x = 64'(v);
    n = '0;
    o = 1'b0;
    a = 1'b0;
    while (x >= (64'd1 << done_bits) && !o && !a)
    begin
      if (n >= step_t'(step_limit))
        a = 1'b1;                        // cap before the explored range
      else
      begin
        if (x[0])
        begin
          x = 3 * x + 1;
          o = (x >> value_bits) != 0;    // counted, then the trial ends
        end
        x = x >> 1;
        n++;
      end
    end
  endtask

  function automatic value_t trajectory_at(input value_t v, input int n);
    value_t x;
    x = v;
    for (int i = 0; i < n; i++)
      x = x[0] ? value_t'((64'(x) * 3 + 1) >> 1) : x >> 1;
    return x;
  endfunction

  // right shifting galois form of x^8+x^6+x^5+x^4+1
  function automatic logic [7:0] next_lfsr(input logic [7:0] s);
    return s[0] ? (s >> 1) ^ 8'hb8 : s >> 1;
  endfunction

  task automatic update_record(input value_t v, input step_t n, input logic o,
                               input logic a);
    if (!o && !a && n > rec_steps) // only strictly longer trials replace it
    begin
      rec_start = v;
      rec_steps = n;
    end
  endtask

  task automatic pulse_load(input value_t v);
    @(posedge clk);
    load       <= 1'b1;
    load_value <= v;                   // held until the next load
    @(posedge clk);
    load       <= 1'b0;
  endtask

  task automatic wait_for_done();
    @(negedge clk);
    while (!done)
      @(negedge clk);
  endtask

  task automatic wait_for_active();
    @(negedge clk);
    while (!active)
      @(negedge clk);
  endtask

  task automatic check_at_done(input value_t v, input logic a);
    check_value("start", start, v);
    check_value("aborted", aborted, a);
    check_value("active", active, 32'd0);
  endtask

  // steps, overflow and record latch on the report edge
  task automatic check_after_done(input step_t n, input logic o);
    @(negedge clk);
    check_value("steps", steps, n);
    check_value("overflow", overflow, o);
    check_value("record_start", record_start, rec_start);
    check_value("record_steps", record_steps, rec_steps);
  endtask

  task automatic apply_trial(input value_t v, input step_t n, input logic o, input logic a);
    update_record(v, n, o, a);
    pulse_load(v);
    wait_for_done();
    check_at_done(v, a);
    check_after_done(n, o);
  endtask

  initial
  begin
    #(watchdog_ns);
    $display("ERRORS FOUND");
    $display("timeout: done never came within %0d ns", watchdog_ns);
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    step_t  n;
    logic   o;
    logic   a;
    value_t v;
    arst_n     = 1'b0;
    clken      = 1'b1;
    run        = 1'b0;
    load       = 1'b0;
    load_value = '0;
    skip       = 1'b0;
    rec_start  = '0;
    rec_steps  = '0;
    lfsr_model = 8'hff;                // reset state of the generator
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("record_start", record_start, 32'd0);
    check_value("record_steps", record_steps, 32'd0);

    // skipped trial of five steps leaves the empty record alone
    pulse_load(32'd27);
    wait_for_active();
    repeat (5) @(posedge clk);
    skip <= 1'b1;
    @(posedge clk);
    skip <= 1'b0;
    wait_for_done();
    check_at_done(32'd27, 1'b1);
    check_after_done(16'd5, 1'b0);

    // table literals are cross checked against the model first
    for (int i = 0; i < num_table; i++)
    begin
      model_trial(table_value[i], n, o, a);
      check_value("model steps", n, table_steps[i]);
      check_value("model overflow", o, table_ovf[i]);
      check_value("model aborted", a, table_abort[i]);
      apply_trial(table_value[i], table_steps[i], table_ovf[i], table_abort[i]);
    end

    for (int i = 0; i < num_random; i++)
    begin
      v = $random(seed);
      if (i % 2 == 0)
        v = v & 32'h0003_ffff;         // shorter trajectories too
      model_trial(v, n, o, a);
      apply_trial(v, n, o, a);
    end

    // freeze after three steps
    model_trial(32'd27, n, o, a);
    pulse_load(32'd27);
    wait_for_active();
    repeat (3) @(posedge clk);
    clken <= 1'b0;
    repeat (6)
    begin
      @(negedge clk);
      check_value("actual", actual, trajectory_at(32'd27, 3));
      check_value("active", active, 32'd1);
    end
    @(posedge clk);
    clken <= 1'b1;
    update_record(32'd27, n, o, a);
    wait_for_done();
    check_at_done(32'd27, a);
    check_after_done(n, o);

    // lfsr trials start from all ones since host trials never advance the generator
    @(posedge clk);
    run <= 1'b1;
    for (int i = 0; i < num_run; i++)
    begin
      model_trial(value_t'(lfsr_model), n, o, a);
      update_record(value_t'(lfsr_model), n, o, a);
      wait_for_done();
      check_at_done(value_t'(lfsr_model), a);
      if (i == num_run - 1)
      begin
        @(posedge clk);
        run <= 1'b0;                   // fsm rests in idle after the report edge
      end
      check_after_done(n, o);
      lfsr_model = next_lfsr(lfsr_model);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* collatz_explorer.f */
hw/collatz_pkg.sv
hw/seed_lfsr.sv
hw/collatz_step.sv
hw/step_tally.sv
hw/collatz_ctrl.sv
hw/collatz_explorer.sv
sim/collatz_explorer_checker.sv
sim/collatz_explorer_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= collatz_explorer_tb
LINT_TOP  ?= collatz_explorer
FILELIST  ?= collatz_explorer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
